// ==== gba_cart_loader.f ====
+incdir+hdl
hdl/gba_loader_pkg.sv
hdl/load_classifier.sv
hdl/flash_id_scanner.sv
hdl/bios_word_packer.sv
hdl/cheat_code_packer.sv
hdl/cart_quirk_detect.sv
hdl/gba_cart_loader.sv
tests/tb_gba_cart_loader.sv

// ==== Makefile ====
# Verilator build and run of the cartridge-load front end testbench
TOP = tb_gba_cart_loader

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f gba_cart_loader.f

# Pass or fail comes from the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== tests/tb_gba_cart_loader.sv ====
//============================
// Self-checking testbench for the cartridge-load front end
// Plays a table of BIOS, cartridge and cheat downloads into the DUT
// and checks every output against values built from the image data
//============================
`timescale 1ns/1ps

module tb_gba_cart_loader
	import gba_loader_pkg::*;
();

	localparam int CLK_PERIOD      = 8;
	localparam int MAX_WORDS       = 128;
	localparam int NUM_ROWS        = 12;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * MAX_WORDS * 4 + 1000;
	localparam int TITLE_BASE      = 'hA0;   // First header title byte
	localparam int EVEN_SPOT       = 200;    // Flash id start, even placement
	localparam int ODD_SPOT        = 211;    // Flash id start, odd placement
	localparam logic [71:0] FLASH_TEXT = "FLASH1M_V";

	// One download per row
	typedef struct packed {
		logic [7:0] index;
		int         words;
		int         place;      // 0 none, 1 even, 2 odd
		int         title_no;   // 0 is a title outside the quirk table
		logic       homebrew;
		quirk_e     quirk;
		logic       flash;
	} row_t;

	localparam row_t ROWS [NUM_ROWS] = '{
		'{8'h00, 64,  0, 0, 1'b0, quirk_none,       1'b0},   // BIOS, written
		'{8'h00, 32,  0, 0, 1'b1, quirk_none,       1'b0},   // BIOS, homebrew selected
		'{8'h01, 120, 0, 1, 1'b0, quirk_sram,       1'b0},
		'{8'h42, 128, 1, 4, 1'b0, quirk_sram_remap, 1'b1},
		'{8'hFF, 32,  0, 0, 1'b0, quirk_none,       1'b0},   // Four cheat records
		'{8'h83, 112, 2, 0, 1'b0, quirk_none,       1'b1},   // Unlisted title
		'{8'hC1, 128, 2, 3, 1'b0, quirk_sram,       1'b1},
		'{8'h05, 116, 1, 6, 1'b0, quirk_sram_remap, 1'b1},
		'{8'h10, 120, 0, 2, 1'b0, quirk_sram,       1'b0},
		'{8'h7F, 112, 0, 5, 1'b0, quirk_sram_remap, 1'b0},
		'{8'hFF, 64,  0, 0, 1'b0, quirk_none,       1'b0},   // Eight cheat records
		'{8'h00, 16,  0, 0, 1'b0, quirk_none,       1'b0}
	};

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	ioctl_addr_t ioctl_addr;
	ioctl_data_t ioctl_dout;
	logic        ioctl_wr;
	logic        homebrew_bios;
	logic        cart_loaded;
	logic [1:0]  cart_type;
	pak_addr_t   max_pak_addr;
	logic        flash_1m;
	bios_addr_t  bios_wraddr;
	bios_word_t  bios_wrdata;
	logic        bios_wr;
	cheat_code_t cheat_code;
	logic        cheat_valid;
	logic        cheat_clear;
	logic        sram_quirk;
	logic        memory_remap_quirk;

	logic [7:0]  img [2*MAX_WORDS];     // Image of the current row, byte per address
	logic [15:0] lfsr_state = 16'd44;
	bios_addr_t  bios_addr_q [$];       // Expected BIOS writes in order
	bios_word_t  bios_data_q [$];
	cheat_code_t cheat_q [$];           // Expected cheat codes in order
	int          clear_count = 0;

	gba_cart_loader i_dut (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	//============================
	// Helpers
	//============================
	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		if (actual !== expected)
			stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
				name, actual, expected));
	endtask

	task automatic step_cycle();
		@(posedge clk_sys);
		#1;                                    // Drive just after the edge
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Galois, taps 16 14 13 11
	endfunction

	task automatic random_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_state[0]};       // One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [95:0] title_text(input int n);
		case (n)
			1: return "ROCKY BOXING";
			2: return "DBZ LGCYGOKU";
			3: return {"IRIDIONII", 24'h0};
			4: return {"SUPER MARIO", 8'h0};
			5: return {"ZELDA 1", 40'h0};
			6: return {"MAPPY", 56'h0};
			default: return "NOT IN TABLE";
		endcase
	endfunction

	// Random filler, then the title line and the flash id for cartridges
	task automatic build_image(input row_t row);
		logic [95:0] title;
		logic [71:0] flash;
		logic [7:0]  b;
		int          spot;
		title = title_text(row.title_no);
		flash = FLASH_TEXT;
		spot = (row.place == 1) ? EVEN_SPOT : ODD_SPOT;
		for (int i = 0; i < 2 * row.words; i++) begin
			random_byte(b);
			img[8'(i)] = b;
		end
		if (row.index != 8'h00 && row.index != 8'hFF) begin
			for (int i = 0; i < 12; i++) begin
				img[8'(TITLE_BASE + i)] = title[95:88];   // First character at 0xA0
				title = title << 8;
			end
			for (int i = 0; i < 9 && row.place != 0; i++) begin
				img[8'(spot + i)] = flash[71:64];
				flash = flash << 8;
			end
		end
	endtask

	//============================
	// One download per table row
	//============================
	task automatic run_row(input row_t row);
		logic [15:0] low_half;
		cheat_code_t code;
		int          base;
		int          clears;
		logic        is_bios;
		logic        is_code;
		is_bios = (row.index == 8'h00);
		is_code = (row.index == 8'hFF);
		clears = clear_count;
		low_half = '0;
		build_image(row);
		ioctl_index = row.index;
		homebrew_bios = row.homebrew;
		ioctl_download = 1'b1;
		repeat (4) step_cycle();               // Idle while the kind settles
		for (int w = 0; w < row.words; w++) begin
			ioctl_addr = ioctl_addr_t'(2 * w);
			ioctl_dout = {img[8'(2 * w + 1)], img[8'(2 * w)]};   // Low byte first in memory
			ioctl_wr = 1'b1;
			if (is_bios && !row.homebrew) begin
				if (!ioctl_addr[1]) begin
					low_half = ioctl_dout;
				end else begin
					bios_addr_q.push_back(ioctl_addr[13:2]);
					bios_data_q.push_back({ioctl_dout, low_half});
				end
			end
			// Record complete, four little-endian values from flags down to replace
			if (is_code && ioctl_addr[3:0] == 4'hE) begin
				base = 2 * w - 14;
				code = '0;
				for (int i = 0; i < 16; i += 4)
					code = {code[95:0], img[8'(base + i + 3)], img[8'(base + i + 2)],
						img[8'(base + i + 1)], img[8'(base + i)]};
				cheat_q.push_back(code);
			end
			step_cycle();
			ioctl_wr = 1'b0;
			repeat (2) step_cycle();
		end
		ioctl_download = 1'b0;
		repeat (6) step_cycle();               // Address held while the end is taken
		check_value("pending bios writes", 128'(bios_addr_q.size()), 128'd0);
		check_value("pending cheat codes", 128'(cheat_q.size()), 128'd0);
		check_value("cheat_clear pulses", 128'(clear_count - clears), 128'(is_code));
		if (!is_bios && !is_code) begin
			check_value("cart_loaded", 128'(cart_loaded), 128'd1);
			check_value("cart_type", 128'(cart_type), 128'(row.index[7:6]));
			check_value("max_pak_addr", 128'(max_pak_addr), 128'((2 * (row.words - 1)) >> 2));
			check_value("flash_1m", 128'(flash_1m), 128'(row.flash));
			check_value("sram_quirk", 128'(sram_quirk), 128'(row.quirk != quirk_none));
			check_value("memory_remap_quirk", 128'(memory_remap_quirk),
				128'(row.quirk == quirk_sram_remap));
		end
	endtask

	// Output monitors, sampled mid-cycle
	always @(negedge clk_sys) begin
		if (!reset && bios_wr) begin
			if (bios_addr_q.size() == 0) begin
				stop_on_error("bios_wr pulsed while no BIOS write was expected");
			end else begin
				check_value("bios_wraddr", 128'(bios_wraddr), 128'(bios_addr_q.pop_front()));
				check_value("bios_wrdata", 128'(bios_wrdata), 128'(bios_data_q.pop_front()));
			end
		end
		if (!reset && cheat_valid) begin
			if (cheat_q.size() == 0)
				stop_on_error("cheat_valid pulsed while no cheat code was expected");
			else
				check_value("cheat_code", 128'(cheat_code), 128'(cheat_q.pop_front()));
		end
		if (!reset && cheat_clear)
			clear_count++;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		stop_on_error("Run timed out before all download rows were finished");
	end

	initial begin
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		homebrew_bios = 1'b0;
		repeat (10) step_cycle();
		reset = 1'b0;
		check_value("outputs after reset", 128'({cart_loaded, flash_1m, sram_quirk,
			memory_remap_quirk, bios_wr, cheat_valid, cheat_clear}), 128'd0);
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(ROWS[r]);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== hdl/gba_cart_loader.sv ====
//============================
// Cartridge-load front end of the emulator core
// Watches the host download stream and hands BIOS writes, cheat codes,
// cartridge facts and game quirks to the core
//============================
`timescale 1ns/1ps

module gba_cart_loader
	import gba_loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	// Host download stream
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  ioctl_addr_t ioctl_addr,
	input  ioctl_data_t ioctl_dout,
	input  logic        ioctl_wr,
	input  logic        homebrew_bios,
	// Cartridge facts
	output logic        cart_loaded,
	output logic [1:0]  cart_type,
	output pak_addr_t   max_pak_addr,
	output logic        flash_1m,
	// BIOS RAM port
	output bios_addr_t  bios_wraddr,
	output bios_word_t  bios_wrdata,
	output logic        bios_wr,
	// Cheat engine
	output cheat_code_t cheat_code,
	output logic        cheat_valid,
	output logic        cheat_clear,
	// Game quirks
	output logic        sram_quirk,
	output logic        memory_remap_quirk
);

	dl_kind_e dl_kind;
	logic     cart_download;
	logic     cart_start;     // First cycle of a cartridge download
	logic     code_start;     // First cycle of a cheat download

	load_classifier i_load_classifier (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr),
		.dl_kind(dl_kind), .cart_download(cart_download),
		.cart_start(cart_start), .code_start(code_start),
		.cart_type(cart_type), .cart_loaded(cart_loaded), .max_pak_addr(max_pak_addr)
	);

	flash_id_scanner i_flash_id_scanner (
		.clk_sys(clk_sys), .reset(reset),
		.cart_download(cart_download), .cart_start(cart_start),
		.ioctl_wr(ioctl_wr), .ioctl_dout(ioctl_dout), .flash_1m(flash_1m)
	);

	bios_word_packer i_bios_word_packer (
		.clk_sys(clk_sys), .reset(reset),
		.dl_kind(dl_kind), .homebrew_bios(homebrew_bios),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.bios_wraddr(bios_wraddr), .bios_wrdata(bios_wrdata), .bios_wr(bios_wr)
	);

	cheat_code_packer i_cheat_code_packer (
		.clk_sys(clk_sys), .reset(reset),
		.dl_kind(dl_kind), .code_start(code_start),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.cheat_code(cheat_code), .cheat_valid(cheat_valid), .cheat_clear(cheat_clear)
	);

	cart_quirk_detect i_cart_quirk_detect (
		.clk_sys(clk_sys), .reset(reset),
		.cart_download(cart_download), .cart_start(cart_start),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.sram_quirk(sram_quirk), .memory_remap_quirk(memory_remap_quirk)
	);

endmodule

// ==== hdl/cart_quirk_detect.sv ====
//============================
// Reads the 12-byte header title of a cartridge
// Flags titles that need the save-memory or the memory-remap quirk
// Outputs settle right after the title line is through
//============================
`timescale 1ns/1ps

`include "gba_loader_defines.svh"

module cart_quirk_detect
	import gba_loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cart_download,
	input  logic        cart_start,
	input  logic        ioctl_wr,
	input  ioctl_addr_t ioctl_addr,
	input  ioctl_data_t ioctl_dout,
	output logic        sram_quirk,
	output logic        memory_remap_quirk
);

	localparam int TITLE_W       = `GBA_TITLE_BYTES * 8;
	localparam int QUIRK_ENTRIES = 6;

	//============================
	// Quirk table
	//============================
	// Titles zero-padded at the end to the full header length
	localparam logic [TITLE_W-1:0] QUIRK_TITLE [QUIRK_ENTRIES] = '{
		"ROCKY BOXING",
		"DBZ LGCYGOKU",
		{"IRIDIONII", 24'h000000},
		{"SUPER MARIO", 8'h00},
		{"ZELDA 1", 40'h0000000000},
		{"MAPPY", 56'h00000000000000}
	};

	localparam quirk_e QUIRK_KIND [QUIRK_ENTRIES] = '{
		quirk_sram,           // Rocky
		quirk_sram,           // Legacy of Goku
		quirk_sram,           // Iridion II
		quirk_sram_remap,     // Classic NES series
		quirk_sram_remap,
		quirk_sram_remap      // Famicom Mini
	};

	logic [TITLE_W-1:0] title;        // First byte in the top bits
	logic [3:0]         line_offset;  // Byte offset in the title line
	logic [6:0]         title_pos;    // Low bit of the two bytes being written
	logic               line_wr;
	quirk_e             title_quirk;

	assign line_offset = ioctl_addr[3:0];
	assign line_wr = cart_download && ioctl_wr &&
		(ioctl_addr[`GBA_IOCTL_ADDR_W-1:4] == `GBA_TITLE_LINE);
	assign title_pos = {4'(`GBA_TITLE_BYTES - 2) - line_offset, 3'b000};

	// Capture, bytes swapped so the title reads as a string
	always_ff @(posedge clk_sys) begin
		if (line_wr && (line_offset < 4'(`GBA_TITLE_BYTES)))
			title[title_pos +: 16] <= {ioctl_dout[7:0], ioctl_dout[15:8]};
	end

	// Table lookup
	always_comb begin
		title_quirk = quirk_none;
		for (int i = 0; i < QUIRK_ENTRIES; i++) begin
			if (title == QUIRK_TITLE[i])
				title_quirk = QUIRK_KIND[i];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset || cart_start) begin
			sram_quirk         <= 1'b0;
			memory_remap_quirk <= 1'b0;
		end else if (line_wr && (line_offset == 4'(`GBA_TITLE_BYTES))) begin
			sram_quirk         <= (title_quirk != quirk_none);        // First word past the title
			memory_remap_quirk <= (title_quirk == quirk_sram_remap);
		end
	end

endmodule

// ==== hdl/cheat_code_packer.sv ====
//============================
// Builds 128-bit cheat codes from 16-byte cheat records
// cheat_valid strobes each finished code, cheat_clear marks a new file
//============================
`timescale 1ns/1ps

module cheat_code_packer
	import gba_loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  dl_kind_e    dl_kind,
	input  logic        code_start,
	input  logic        ioctl_wr,
	input  ioctl_addr_t ioctl_addr,
	input  ioctl_data_t ioctl_dout,
	output cheat_code_t cheat_code,
	output logic        cheat_valid,
	output logic        cheat_clear
);

	logic       code_take;    // Word of a cheat record
	logic [2:0] slot;         // Word number within the record
	logic [6:0] field_pos;    // Low bit of the 16-bit field
	logic       last_slot;

	assign code_take = (dl_kind == dl_code) && ioctl_wr && !ioctl_addr[0];
	assign slot      = ioctl_addr[3:1];
	assign last_slot = (slot == 3'd7);   // Offset 14, top half of replace

	// Records hold flags, address, compare, replace from the top down
	// Each 32-bit value arrives bottom half first
	assign field_pos = {~slot[2:1], slot[0], 4'b0000};

	// New cheat file wipes the active list in the core
	assign cheat_clear = code_start;

	//============================
	// Code assembly
	//============================
	always_ff @(posedge clk_sys) begin
		if (code_take)
			cheat_code[field_pos +: 16] <= ioctl_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= code_take && last_slot;   // Code complete, clock it in
	end

endmodule

// ==== hdl/bios_word_packer.sv ====
//============================
// Packs 16-bit BIOS download words into 32-bit BIOS RAM writes
// Quiet while the homebrew BIOS is selected
//============================
`timescale 1ns/1ps

`include "gba_loader_defines.svh"

module bios_word_packer
	import gba_loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  dl_kind_e    dl_kind,
	input  logic        homebrew_bios,
	input  logic        ioctl_wr,
	input  ioctl_addr_t ioctl_addr,
	input  ioctl_data_t ioctl_dout,
	output bios_addr_t  bios_wraddr,
	output bios_word_t  bios_wrdata,
	output logic        bios_wr
);

	logic bios_take;      // BIOS word accepted this cycle

	assign bios_take = (dl_kind == dl_bios) && ioctl_wr && !homebrew_bios;

	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr <= 1'b0;
		else
			bios_wr <= bios_take && ioctl_addr[1];  // Upper half completes the word
	end

	// Halves and address
	always_ff @(posedge clk_sys) begin
		if (bios_take) begin
			if (!ioctl_addr[1]) begin
				bios_wrdata[`GBA_IOCTL_DATA_W-1:0] <= ioctl_dout;
			end else begin
				bios_wrdata[2*`GBA_IOCTL_DATA_W-1:`GBA_IOCTL_DATA_W] <= ioctl_dout;
				bios_wraddr <= ioctl_addr[`GBA_BIOS_ADDR_W+1:2];
			end
		end
	end

	// One write per word pair
	assert property (@(posedge clk_sys) disable iff (reset) bios_wr |=> !bios_wr);

endmodule

// ==== hdl/flash_id_scanner.sv ====
//============================
// Scans the cartridge stream for the FLASH1M_V id string
// flash_1m selects the 128 KB flash save type in the core
//============================
`timescale 1ns/1ps

module flash_id_scanner
	import gba_loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cart_download,
	input  logic        cart_start,
	input  logic        ioctl_wr,
	input  ioctl_data_t ioctl_dout,
	output logic        flash_1m
);

	localparam logic [71:0] FLASH_ID = "FLASH1M_V";   // Nine bytes

	logic [63:0] window;      // Last eight bytes, newest at the bottom
	logic [7:0]  lo_byte;     // First byte of the word in memory order
	logic [7:0]  hi_byte;
	logic        cart_wr;
	logic        hit_lo;
	logic        hit_hi;

	assign lo_byte = ioctl_dout[7:0];
	assign hi_byte = ioctl_dout[15:8];
	assign cart_wr = cart_download && ioctl_wr;
	assign hit_lo = ({window, lo_byte} == FLASH_ID);             // String ends on the low byte
	assign hit_hi = ({window[55:0], lo_byte, hi_byte} == FLASH_ID); // Ends on the high byte

	always_ff @(posedge clk_sys) begin
		if (cart_start)
			window <= '0;                          // No carry-over from the last image
		else if (cart_wr)
			window <= {window[47:0], lo_byte, hi_byte};
	end

	always_ff @(posedge clk_sys) begin
		if (reset || cart_start)
			flash_1m <= 1'b0;
		else if (cart_wr && (hit_lo || hit_hi))
			flash_1m <= 1'b1;                      // Held until the next cartridge
	end

endmodule

// ==== hdl/load_classifier.sv ====
//============================
// Classifies the host download by image index
// Gives the download kind, start pulses and the cartridge facts
// that stay valid after the image has been loaded
//============================
`timescale 1ns/1ps

`include "gba_loader_defines.svh"

module load_classifier
	import gba_loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  ioctl_addr_t ioctl_addr,
	output dl_kind_e    dl_kind,
	output logic        cart_download,
	output logic        cart_start,
	output logic        code_start,
	output logic [1:0]  cart_type,
	output logic        cart_loaded,
	output pak_addr_t   max_pak_addr
);

	dl_kind_e kind_q;      // dl_kind one cycle back, for edge detection
	logic     cart_rise;
	logic     cart_fall;
	logic     code_rise;

	assign cart_download = (dl_kind == dl_cart);   // Decoded from the kind register
	assign cart_rise = cart_download && (kind_q != dl_cart);
	assign cart_fall = !cart_download && (kind_q == dl_cart);
	assign code_rise = (dl_kind == dl_code) && (kind_q != dl_code);

	//============================
	// Kind register and pulses
	//============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_kind     <= dl_none;
			kind_q      <= dl_none;
			cart_start  <= 1'b0;
			code_start  <= 1'b0;
			cart_type   <= 2'd0;
			cart_loaded <= 1'b0;
		end else begin
			if (!ioctl_download)
				dl_kind <= dl_none;
			else if (ioctl_index == `GBA_BIOS_INDEX)
				dl_kind <= dl_bios;
			else if (ioctl_index == `GBA_CODE_INDEX)
				dl_kind <= dl_code;
			else
				dl_kind <= dl_cart;                  // Any other index is a cartridge
			kind_q     <= dl_kind;
			cart_start <= cart_rise;
			code_start <= code_rise;
			if (cart_rise) begin
				cart_type   <= ioctl_index[7:6];     // Type sits in the top index bits
				cart_loaded <= 1'b1;                 // Sticky until reset
			end
		end
	end

	// Host holds the last address until after the download drops
	always_ff @(posedge clk_sys) begin
		if (cart_fall)
			max_pak_addr <= ioctl_addr[`GBA_IOCTL_ADDR_W-1:2];
	end

	// Loaded flag only ever clears through reset
	assert property (@(posedge clk_sys) disable iff (reset)
		$fell(cart_loaded) |-> $past(reset));

endmodule

// ==== hdl/gba_loader_pkg.sv ====
//============================
// Shared types for the cartridge-load front end
// Modules take these by a wildcard import in the header
//============================
package gba_loader_pkg;

`include "gba_loader_defines.svh"

	// Download stream
	typedef logic [`GBA_IOCTL_ADDR_W-1:0] ioctl_addr_t;    // Byte address
	typedef logic [`GBA_IOCTL_DATA_W-1:0] ioctl_data_t;    // 16-bit word

	// BIOS RAM write port
	typedef logic [`GBA_BIOS_ADDR_W-1:0]    bios_addr_t;   // Word address
	typedef logic [2*`GBA_IOCTL_DATA_W-1:0] bios_word_t;   // Two download words

	// Cartridge word address, byte address without the two low bits
	typedef logic [`GBA_IOCTL_ADDR_W-3:0] pak_addr_t;

	// Cheat code layout
	// 127:96 flags, 95:64 address, 63:32 compare, 31:0 replace
	typedef logic [`GBA_CHEAT_W-1:0] cheat_code_t;

	// What the host is currently sending
	typedef enum logic [1:0] {
		dl_none,
		dl_bios,
		dl_cart,
		dl_code
	} dl_kind_e;

	// Quirk attached to a header title
	typedef enum logic [1:0] {
		quirk_none,
		quirk_sram,        // Save memory quirk only
		quirk_sram_remap   // Save memory quirk plus memory remap
	} quirk_e;

endpackage

// ==== hdl/gba_loader_defines.svh ====
//============================
// Widths, image indices and header offsets for the cartridge-load front end
// Include wherever a width or a fixed index is needed
//============================
`ifndef GBA_LOADER_DEFINES_SVH
`define GBA_LOADER_DEFINES_SVH

// Host download stream
`define GBA_IOCTL_ADDR_W 27       // Byte address
`define GBA_IOCTL_DATA_W 16       // One download word

// BIOS RAM side
`define GBA_BIOS_ADDR_W  12       // 32-bit word address into 16 KB BIOS

//============================
// Image indices
//============================
`define GBA_BIOS_INDEX   8'd0     // BIOS image
`define GBA_CODE_INDEX   8'd255   // Cheat file

//============================
// Cartridge header
//============================
`define GBA_TITLE_LINE   23'hA    // Address bits 26:4 of the title line (0xA0..0xAF)
`define GBA_TITLE_BYTES  12       // Title length, also the offset where it is checked

// Cheat record
`define GBA_CHEAT_W      128      // Flags, address, compare, replace

`endif
